/* hw/digit_pad_pkg.sv */
`default_nettype none

package digit_pad_pkg;

    // canvas is square, one bit per cell
    localparam int CANVAS_DIM = 30;

    // cursor or pixel position, 0..29
    typedef logic [4:0] coord_t;
    // streamed pixel, 0 blank, 255 ink
    typedef logic [7:0] pixel_t;
    // classifier result, 0..9
    typedef logic [3:0] digit_t;
    // ink bitmap, cell index y*30+x
    typedef logic [CANVAS_DIM*CANVAS_DIM-1:0] canvas_t;
    // ink count of one 10x10 zone, max 100
    typedef logic [6:0] zone_cnt_t;
    // active-low segments, gfedcba
    typedef logic [6:0] seg_t;

    // decoded mouse packet, moves are two's complement
    typedef struct packed {
        logic              btn_left;
        logic              btn_right;
        logic signed [8:0] dx;
        logic signed [8:0] dy;
    } mouse_pkt_t;

    // one beat of the raster pixel stream
    typedef struct packed {
        pixel_t pixel;
        coord_t x;
        coord_t y;
    } pix_beat_t;

    // hex glyphs 0..F, segment low means lit
    localparam seg_t SEG_HEX [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

`default_nettype wire

/* hw/key_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  wire  i_clk,
    input  wire  i_rst,
    input  logic i_key_n,
    output logic o_press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    // count value at which the key counts as held
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             key_q;
    logic [CNT_W-1:0] stable_cnt;
    logic             armed;
    logic             key_stable;

    // raw key matches last sample
    assign key_stable = (i_key_n == key_q);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // idle level of the key is high
            key_q      <= 1'b1;
            stable_cnt <= '0;
            armed      <= 1'b0;
            o_press    <= 1'b0;
        end else begin
            key_q   <= i_key_n;
            o_press <= 1'b0;
            // any edge restarts the stability count
            if (!key_stable) begin
                stable_cnt <= '0;
            end else if (stable_cnt != HOLD_LAST) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            // re-arm once released
            if (key_q) begin
                armed <= 1'b1;
            end
            // held low long enough, fire once
            if (armed && !key_q && key_stable && stable_cnt == HOLD_LAST) begin
                o_press <= 1'b1;
                armed   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/canvas_cursor.sv */
`timescale 1ns/1ps
`default_nettype none

module canvas_cursor
    import digit_pad_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst,
    input  logic       i_mouse_valid,
    input  mouse_pkt_t i_mouse_pkt,
    output canvas_t    o_canvas
);

    // upper clamp bound as an 11-bit signed value
    localparam logic signed [10:0] MAX_POS = 11'(CANVAS_DIM - 1);

    coord_t     cur_x;
    coord_t     cur_y;
    coord_t     nx_x;
    coord_t     nx_y;
    logic [9:0] cell_idx;
    canvas_t    canvas_q;

    // apply a signed move and clamp into 0..29
    function automatic coord_t clamp_step(input coord_t pos, input logic signed [8:0] delta);
        logic signed [10:0] sum;
        sum = $signed({6'b000000, pos}) + {{2{delta[8]}}, delta};
        if (sum < 0) begin
            return '0;
        end else if (sum > MAX_POS) begin
            return MAX_POS[4:0];
        end else begin
            return sum[4:0];
        end
    endfunction

    // next cursor position for the incoming packet
    always_comb begin
        nx_x = clamp_step(cur_x, i_mouse_pkt.dx);
        nx_y = clamp_step(cur_y, i_mouse_pkt.dy);
        // row-major cell under the new cursor
        cell_idx = 10'(nx_y) * 10'(CANVAS_DIM) + 10'(nx_x);
    end

    // cursor registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (i_mouse_valid) begin
            cur_x <= nx_x;
            cur_y <= nx_y;
        end
    end

    // ink bitmap
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            canvas_q <= '0;
        end else if (i_mouse_valid) begin
            // right button wipes, left button ignored then
            if (i_mouse_pkt.btn_right) begin
                canvas_q <= '0;
            end else if (i_mouse_pkt.btn_left) begin
                // ink lands at the moved position
                canvas_q[cell_idx] <= 1'b1;
            end
        end
    end

    assign o_canvas = canvas_q;

endmodule

`default_nettype wire

/* hw/canvas_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module canvas_serializer
    import digit_pad_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst,
    input  logic      i_press,
    input  canvas_t   i_canvas,
    output logic      o_pix_valid,
    output pix_beat_t o_pix
);

    localparam coord_t LAST_POS = coord_t'(CANVAS_DIM - 1);

    typedef enum logic {
        IDLE,
        STREAM
    } state_t;

    state_t     state;
    canvas_t    snap;
    coord_t     x_cnt;
    coord_t     y_cnt;
    logic [9:0] rd_idx;

    // raster position into the snapshot
    assign rd_idx = 10'(y_cnt) * 10'(CANVAS_DIM) + 10'(x_cnt);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= IDLE;
            x_cnt       <= '0;
            y_cnt       <= '0;
            o_pix_valid <= 1'b0;
        end else begin
            // one beat per cycle while streaming
            o_pix_valid <= (state == STREAM);
            case (state)
                IDLE: begin
                    if (i_press) begin
                        state <= STREAM;
                        x_cnt <= '0;
                        y_cnt <= '0;
                    end
                end
                STREAM: begin
                    // presses here are dropped
                    if (x_cnt == LAST_POS) begin
                        x_cnt <= '0;
                        if (y_cnt == LAST_POS) begin
                            y_cnt <= '0;
                            state <= IDLE;
                        end else begin
                            y_cnt <= y_cnt + 1'b1;
                        end
                    end else begin
                        x_cnt <= x_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // freeze the canvas so drawing during a stream has no effect
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_press) begin
            snap <= i_canvas;
        end
    end

    // beat payload, ink maps to full scale
    always_ff @(posedge i_clk) begin
        if (state == STREAM) begin
            o_pix.pixel <= snap[rd_idx] ? 8'd255 : 8'd0;
            o_pix.x     <= x_cnt;
            o_pix.y     <= y_cnt;
        end
    end

endmodule

`default_nettype wire

/* hw/ink_zone_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module ink_zone_classifier
    import digit_pad_pkg::*;
(
    input  wire       i_clk,
    input  wire       i_rst,
    input  logic      i_pix_valid,
    input  pix_beat_t i_pix,
    output digit_t    o_digit,
    output logic      o_digit_valid
);

    localparam int     NUM_ZONES = 9;
    localparam int     ZONE_DIM  = CANVAS_DIM / 3;
    localparam coord_t LAST_POS  = coord_t'(CANVAS_DIM - 1);

    zone_cnt_t            zone_cnt [NUM_ZONES];
    zone_cnt_t            cnt_next [NUM_ZONES];
    logic [NUM_ZONES-1:0] hit;
    logic [3:0]           zone_id;
    logic                 ink;
    logic                 last_beat;
    zone_cnt_t            best_cnt;
    digit_t               best_idx;

    // which third of the canvas a coordinate falls in
    function automatic logic [1:0] band(input coord_t c);
        if (c < coord_t'(ZONE_DIM)) begin
            return 2'd0;
        end else if (c < coord_t'(2 * ZONE_DIM)) begin
            return 2'd1;
        end else begin
            return 2'd2;
        end
    endfunction

    // msb set counts as ink
    assign ink       = i_pix.pixel[7];
    assign last_beat = (i_pix.x == LAST_POS) && (i_pix.y == LAST_POS);
    // zones numbered row by row
    assign zone_id   = 4'(band(i_pix.y)) * 4'd3 + 4'(band(i_pix.x));

    always_comb begin
        // counts including the current beat
        for (int i = 0; i < NUM_ZONES; i++) begin
            hit[i]      = i_pix_valid && ink && (zone_id == 4'(i));
            cnt_next[i] = zone_cnt[i] + zone_cnt_t'(hit[i]);
        end
        // strict compare keeps the first maximum
        // all zero leaves the blank answer 9
        best_cnt = '0;
        best_idx = 4'd9;
        for (int i = 0; i < NUM_ZONES; i++) begin
            if (cnt_next[i] > best_cnt) begin
                best_cnt = cnt_next[i];
                best_idx = digit_t'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_ZONES; i++) begin
                zone_cnt[i] <= '0;
            end
            o_digit       <= '0;
            o_digit_valid <= 1'b0;
        end else begin
            o_digit_valid <= i_pix_valid && last_beat;
            if (i_pix_valid) begin
                if (last_beat) begin
                    // result out, counters ready for next stream
                    o_digit <= best_idx;
                    for (int i = 0; i < NUM_ZONES; i++) begin
                        zone_cnt[i] <= '0;
                    end
                end else begin
                    for (int i = 0; i < NUM_ZONES; i++) begin
                        zone_cnt[i] <= cnt_next[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/event_counter_display.sv */
`timescale 1ns/1ps
`default_nettype none

module event_counter_display
    import digit_pad_pkg::*;
#(
    parameter int CNT_WIDTH = 8
) (
    input  wire  i_clk,
    input  wire  i_rst,
    input  logic i_event,
    output seg_t o_seg_hi,
    output seg_t o_seg_lo
);

    logic [CNT_WIDTH-1:0] cnt;
    // two hex digits show the low byte
    logic [7:0]           cnt_byte;

    // one per strobe cycle, wraps naturally
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt <= '0;
        end else if (i_event) begin
            cnt <= cnt + 1'b1;
        end
    end

    // zero-extends narrow counters, drops upper bits of wide ones
    assign cnt_byte = 8'(cnt);

    // glyph lookup straight from the register
    assign o_seg_hi = SEG_HEX[cnt_byte[7:4]];
    assign o_seg_lo = SEG_HEX[cnt_byte[3:0]];

endmodule

`default_nettype wire

/* hw/digit_pad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_pad_top
    import digit_pad_pkg::*;
#(
    // 5 ms at 50 MHz on the board
    parameter int DEBOUNCE_CYCLES = 250000,
    parameter int CNT_WIDTH       = 8
) (
    input  wire        i_clk,
    input  wire        i_rst,
    input  logic       i_key_n,
    input  logic       i_mouse_valid,
    input  mouse_pkt_t i_mouse_pkt,
    output digit_t     o_digit,
    output logic       o_digit_valid,
    output seg_t       o_hex_digit_hi,
    output seg_t       o_hex_digit_lo,
    output seg_t       o_hex_pix_hi,
    output seg_t       o_hex_pix_lo
);

    logic      press;
    canvas_t   canvas;
    logic      pix_valid;
    pix_beat_t pix;

    // classify key
    key_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_debounce (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_key_n(i_key_n),
        .o_press(press)
    );

    // drawing surface
    canvas_cursor u_cursor (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_mouse_valid(i_mouse_valid),
        .i_mouse_pkt  (i_mouse_pkt),
        .o_canvas     (canvas)
    );

    // snapshot to raster stream
    canvas_serializer u_serializer (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_press    (press),
        .i_canvas   (canvas),
        .o_pix_valid(pix_valid),
        .o_pix      (pix)
    );

    // stream to digit
    ink_zone_classifier u_classifier (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .o_digit      (o_digit),
        .o_digit_valid(o_digit_valid)
    );

    // number of results so far
    event_counter_display #(
        .CNT_WIDTH(CNT_WIDTH)
    ) u_cnt_digit (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_event (o_digit_valid),
        .o_seg_hi(o_hex_digit_hi),
        .o_seg_lo(o_hex_digit_lo)
    );

    // streamed beats, 900 per classification
    event_counter_display #(
        .CNT_WIDTH(CNT_WIDTH)
    ) u_cnt_pix (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_event (pix_valid),
        .o_seg_hi(o_hex_pix_hi),
        .o_seg_lo(o_hex_pix_lo)
    );

endmodule

`default_nettype wire

/* verif/digit_pad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_pad_tb
    import digit_pad_pkg::*;
();

    localparam string PATTERN_FILE = "verif/digit_pad_patterns.txt";

    // active-low hex glyphs gfedcba
    localparam logic [6:0] GLYPH [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       key_n;
    logic       mouse_valid;
    mouse_pkt_t mouse_pkt;
    digit_t     digit;
    logic       digit_valid;
    seg_t       hex_digit_hi;
    seg_t       hex_digit_lo;
    seg_t       hex_pix_hi;
    seg_t       hex_pix_lo;

    int     cycles = 0;
    int     cycle_limit = 0;
    int     n_results = 0;
    digit_t last_digit = '0;
    int     n_expects = 0;
    int     n_tests = 0;
    int     n_errors = 0;
    // classify commands since the last expect
    int     presses_pending = 0;

    digit_pad_top #(
        .DEBOUNCE_CYCLES(4),
        .CNT_WIDTH      (8)
    ) i_dut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_key_n       (key_n),
        .i_mouse_valid (mouse_valid),
        .i_mouse_pkt   (mouse_pkt),
        .o_digit       (digit),
        .o_digit_valid (digit_valid),
        .o_hex_digit_hi(hex_digit_hi),
        .o_hex_digit_lo(hex_digit_lo),
        .o_hex_pix_hi  (hex_pix_hi),
        .o_hex_pix_lo  (hex_pix_lo)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // result monitor sampled mid-cycle
    always @(negedge clk) begin
        if (digit_valid) begin
            n_results = n_results + 1;
            last_digit = digit;
        end
    end

    // run limit from the number of classify commands
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // one packet strobe then a short random idle gap
    task automatic send_packet(input int dx, input int dy, input logic left, input logic right);
        int gap;
        gap = int'($urandom % 4);
        step();
        mouse_pkt.btn_left  = left;
        mouse_pkt.btn_right = right;
        mouse_pkt.dx        = 9'(dx);
        mouse_pkt.dy        = 9'(dy);
        mouse_valid         = 1'b1;
        step();
        mouse_valid = 1'b0;
        repeat (gap) step();
    endtask

    // key low 6 cycles then released long enough to re-arm
    task automatic press_key();
        step();
        key_n = 1'b0;
        repeat (6) step();
        key_n = 1'b1;
        repeat (2) step();
    endtask

    // checks one stream result and both display pairs
    task automatic check_result(input int expected);
        logic [7:0] n_byte;
        logic [7:0] pix_byte;
        logic       ok;
        while (n_results <= n_expects) @(posedge clk);
        // a dropped press would show up as a second pulse within a stream length
        if (presses_pending > 1) begin
            repeat (910) @(posedge clk);
        end
        @(negedge clk);
        ok = 1'b1;
        n_tests = n_tests + 1;
        if (last_digit !== digit_t'(expected)) begin
            $display("Fail at %0t: digit %0d, expected %0d", $time, last_digit, expected);
            ok = 1'b0;
        end
        n_expects = n_expects + 1;
        n_byte = 8'(n_expects);
        // 900 beats per stream and only the low byte shown
        pix_byte = 8'(n_expects * 900);
        if (hex_digit_hi !== GLYPH[n_byte[7:4]] || hex_digit_lo !== GLYPH[n_byte[3:0]]) begin
            $display("Fail at %0t: result count display wrong for count %0d", $time, n_expects);
            ok = 1'b0;
        end
        if (hex_pix_hi !== GLYPH[pix_byte[7:4]] || hex_pix_lo !== GLYPH[pix_byte[3:0]]) begin
            $display("Fail at %0t: pixel count display wrong, expected %02h", $time, pix_byte);
            ok = 1'b0;
        end
        if (n_results != n_expects) begin
            $display("more digit results came out than streams were started");
            ok = 1'b0;
            n_expects = n_results;
        end
        if (!ok) begin
            n_errors = n_errors + 1;
        end
        presses_pending = 0;
        $display("test %0d: expect digit %0d, %s", n_tests, expected, ok ? "ok" : "mismatch");
    endtask

    initial begin
        int    fd;
        int    code;
        int    n_classify;
        int    a;
        int    b;
        int    l;
        int    r;
        logic  ok;
        string line;
        key_n       = 1'b1;
        mouse_valid = 1'b0;
        mouse_pkt   = '0;
        rst         = 1'b1;
        void'($urandom(25));
        // first pass only counts classify commands
        n_classify = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
            $display("RESULT: FAIL");
            $finish;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] == "c") begin
                n_classify = n_classify + 1;
            end
        end
        $fclose(fd);
        cycle_limit = n_classify * 1000 + 2000;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle outputs after reset
        ok = 1'b1;
        repeat (5) begin
            @(negedge clk);
            if (digit_valid !== 1'b0 || digit !== 4'd0) begin
                $display("Fail at %0t: classifier output active after reset", $time);
                ok = 1'b0;
            end
            if (hex_digit_hi !== GLYPH[0] || hex_digit_lo !== GLYPH[0] ||
                hex_pix_hi !== GLYPH[0] || hex_pix_lo !== GLYPH[0]) begin
                $display("Fail at %0t: display not showing 00 after reset", $time);
                ok = 1'b0;
            end
        end
        n_tests = n_tests + 1;
        if (!ok) begin
            n_errors = n_errors + 1;
        end
        $display("test %0d: reset state, %s", n_tests, ok ? "ok" : "mismatch");

        fd = $fopen(PATTERN_FILE, "r");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                case (line[0])
                    "m": begin
                        code = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", a, b, l, r);
                        send_packet(a, b, l[0], r[0]);
                    end
                    "c": begin
                        presses_pending = presses_pending + 1;
                        press_key();
                    end
                    "e": begin
                        code = $sscanf(line.substr(1, line.len() - 1), "%d", a);
                        check_result(a);
                    end
                    default: begin
                        $display("unknown command in pattern file: %s", line);
                        n_errors = n_errors + 1;
                    end
                endcase
            end
        end
        $fclose(fd);

        // nothing more may arrive once all streams are checked
        repeat (920) @(posedge clk);
        if (n_results != n_expects) begin
            $display("a digit result arrived after the last expected one");
            n_errors = n_errors + 1;
        end
        $display("tests %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/digit_pad_patterns.txt */
# m dx dy left right : one mouse packet, moves are signed
# c : classify key press    e digit : expected result of the last stream
c
e 9
m -5 -5 1 0
m 3 2 1 0
c
e 0
m 0 0 0 1
m 40 40 1 0
m -2 0 1 0
c
e 8
m 0 0 0 1
m 100 -100 1 0
m -3 5 1 0
c
e 2
m 0 0 0 1
m -11 10 1 0
m 1 0 1 0
m 1 0 1 0
m -10 0 1 0
c
e 4
m 0 0 0 1
m 0 10 1 0
m 10 0 1 0
m 1 0 1 0
m -10 0 1 0
c
e 6
m 0 0 1 1
c
e 9
m 5 -10 1 0
c
c
e 4
m 10 0 0 0
m 0 1 1 0
m 1 0 1 0
c
e 5
m 0 0 0 1
m -10 -15 1 0
c
e 1

/* flist.f */
hw/digit_pad_pkg.sv
hw/key_debounce.sv
hw/canvas_cursor.sv
hw/canvas_serializer.sv
hw/ink_zone_classifier.sv
hw/event_counter_display.sv
hw/digit_pad_top.sv
verif/digit_pad_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = digit_pad_tb
FILELIST = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
